// ==== list.f ====
design/loader_pkg.sv
design/crt_parser.sv
design/download_decoder.sv
design/dma_slot_ctrl.sv
design/tape_fetch.sv
design/loader_top.sv
bench/loader_sva.sv
bench/tb_loader_top.sv

// ==== Makefile ====
SRCS := $(wildcard design/*.sv bench/*.sv)
SIM  := obj_dir/Vtb_loader_top

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_loader_top -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

// ==== bench/tb_loader_top.sv ====
// Testbench for the loader top level
// Table of PRG, CRT and TAP downloads with a write log and memory model
// Random slot gaps, tape playback, FIFO full and play toggle checks

`timescale 1ns/1ps

module tb_loader_top;
	import loader_pkg::*;

	typedef struct {
		file_kind_e  kind;
		logic [15:0] param;
		int          pay_len;
	} rec_t;

	logic       clk_sys;
	logic       reset_n;
	dl_byte_t   dl_i;
	file_kind_e index_i;
	logic       download_i;
	logic       slot_i;
	logic [7:0] mem_rdata_i;
	logic       play_btn_i;
	logic       fifo_full_i;
	logic       wait_o;
	mem_req_t   mem_o;
	cart_info_t cart_o;
	chip_hdr_t  chip_o;
	logic       cart_attached_o;
	logic       tap_mode_o;
	tap_byte_t  tap_byte_o;
	logic       playing_o;

	rec_t              recs [3];
	logic [7:0]        file_q [$];
	logic [ADDR_W-1:0] exp_addr [$];
	logic [7:0]        exp_data [$];
	logic [ADDR_W-1:0] wr_addr [$];
	logic [7:0]        wr_data [$];
	chip_hdr_t         exp_chip [$];
	chip_hdr_t         seen_chip [$];
	logic [7:0]        tap_q [$];
	logic [7:0]        mem [int];
	logic              slot_q;
	logic              fifo_q;
	int                n;

	loader_top loader_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic fail_msg(input string msg);
		$display("%s", msg);
		abort_run();
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// Read value of a location that was never written
	function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]};
	endfunction

	// ==============================
	// Memory model and monitors
	// ==============================
	always @(posedge clk_sys) begin
		slot_q <= slot_i;
		fifo_q <= fifo_full_i;
		if (slot_i && !slot_q && mem_o.ce) begin
			if (mem_o.we) begin
				mem[int'(mem_o.addr)] = mem_o.data;
				wr_addr.push_back(mem_o.addr);
				wr_data.push_back(mem_o.data);
			end else begin
				mem_rdata_i <= mem.exists(int'(mem_o.addr)) ? mem[int'(mem_o.addr)] :
					fill_byte(mem_o.addr);
			end
		end
		if (chip_o.valid)
			seen_chip.push_back(chip_o);
		if (tap_byte_o.valid)
			tap_q.push_back(tap_byte_o.data);
		assert (!(tap_byte_o.valid && fifo_q)) else
			fail_msg("tape byte delivered while the FIFO was full");
	end

	// Slots of 1 or 2 cycles with random gaps
	initial begin
		void'($urandom(32'h8d2d_3ffe));
		slot_i = 1'b0;
		@(posedge reset_n);
		forever begin
			@(negedge clk_sys);
			slot_i = 1'b1;
			repeat (1 + $urandom % 2) @(negedge clk_sys);
			slot_i = 1'b0;
			repeat ($urandom % 6) @(negedge clk_sys);
		end
	end

	function automatic logic [7:0] pat(input int r, input int i);
		return 8'((i * 29 + r * 71 + 5) ^ (i >> 3));
	endfunction

	task automatic add_chip(input logic [15:0] bank, input logic [15:0] laddr,
			input int size, input logic [ADDR_W-1:0] dest);
		logic [31:0] len;
		len = 32'(size + CHIP_HDR_LEN);
		file_q.push_back(8'h43);
		file_q.push_back(8'h48);
		file_q.push_back(8'h49);
		file_q.push_back(8'h50);
		for (int k = 3; k >= 0; k--)
			file_q.push_back(len[k*8 +: 8]);
		file_q.push_back(8'h00);
		file_q.push_back(8'h02);
		file_q.push_back(bank[15:8]);
		file_q.push_back(bank[7:0]);
		file_q.push_back(laddr[15:8]);
		file_q.push_back(laddr[7:0]);
		file_q.push_back(8'(size >> 8));
		file_q.push_back(8'(size));
		exp_chip.push_back({1'b1, 8'h02, bank, laddr, 16'(size)});
		for (int k = 0; k < size; k++) begin
			file_q.push_back(pat(1, k + int'(bank) * 50));
			exp_addr.push_back(dest + ADDR_W'(k));
			exp_data.push_back(pat(1, k + int'(bank) * 50));
		end
	endtask

	// Builds the file bytes and expected writes of one table record
	task automatic build_file(input int r);
		file_q.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_chip.delete();
		case (recs[r].kind)
			KIND_PRG: begin
				file_q.push_back(recs[r].param[7:0]);
				file_q.push_back(recs[r].param[15:8]);
				for (int i = 0; i < recs[r].pay_len; i++) begin
					file_q.push_back(pat(r, i));
					exp_addr.push_back(ADDR_W'(recs[r].param) + ADDR_W'(i));
					exp_data.push_back(pat(r, i));
				end
			end
			KIND_CRT: begin
				for (int i = 0; i < CRT_CHIP_START; i++)
					file_q.push_back(8'hff);
				file_q[16'h16] = recs[r].param[15:8];
				file_q[16'h17] = recs[r].param[7:0];
				file_q[16'h18] = 8'h01;
				file_q[16'h19] = 8'h00;
				add_chip(16'd0, 16'h8000, recs[r].pay_len, CART_BASE);
				add_chip(16'd1, 16'ha000, 24, CART_BASE + ADDR_W'('h2000));
			end
			default: begin
				for (int i = 0; i < recs[r].pay_len; i++) begin
					file_q.push_back(i == TAP_MODE_OFS ? recs[r].param[7:0] : pat(r, i));
					exp_addr.push_back(TAP_BASE + ADDR_W'(i));
					exp_data.push_back(file_q[i]);
				end
			end
		endcase
	endtask

	task automatic wait_ready();
		int cnt;
		cnt = 0;
		@(posedge clk_sys);
		while (wait_o) begin
			@(posedge clk_sys);
			cnt++;
			if (cnt > 200)
				fail_msg("wait_o stayed high, no slot committed the pending byte");
		end
		@(negedge clk_sys);
	endtask

	task automatic run_download(input file_kind_e kind);
		index_i = kind;
		@(negedge clk_sys);
		download_i = 1'b1;
		for (int i = 0; i < file_q.size(); i++) begin
			wait_ready();
			dl_i = {1'b1, ADDR_W'(i), file_q[i]};
			@(negedge clk_sys);
			dl_i.wr = 1'b0;
			// wait_o reacts two or three cycles after a strobe
			repeat (3) @(negedge clk_sys);
		end
		wait_ready();
		download_i = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic wait_tap_count(input int cnt);
		int t;
		t = 0;
		while (tap_q.size() < cnt) begin
			@(negedge clk_sys);
			t++;
			if (t > 3000)
				fail_msg("tape bytes stopped arriving");
		end
	endtask

	task automatic press_play();
		play_btn_i = 1'b1;
		repeat (2) @(negedge clk_sys);
		play_btn_i = 1'b0;
		repeat (10) @(negedge clk_sys);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		reset_n     = 1'b0;
		dl_i        = '0;
		index_i     = KIND_PRG;
		download_i  = 1'b0;
		mem_rdata_i = 8'h00;
		play_btn_i  = 1'b0;
		fifo_full_i = 1'b0;
		recs[0] = '{KIND_PRG, 16'h0801, 20};
		recs[1] = '{KIND_CRT, 16'h0013, 40};
		recs[2] = '{KIND_TAP, 16'h0001, 40};
		repeat (3) @(negedge clk_sys);
		reset_n = 1'b1;
		check_val("mem_o.ce", mem_o.ce, 0);
		check_val("mem_o.we", mem_o.we, 0);
		check_val("wait_o", wait_o, 0);
		check_val("playing_o", playing_o, 0);
		check_val("tap_byte_o.valid", tap_byte_o.valid, 0);
		check_val("cart_attached_o", cart_attached_o, 0);

		for (int r = 0; r < 3; r++) begin
			build_file(r);
			wr_addr.delete();
			wr_data.delete();
			seen_chip.delete();
			run_download(recs[r].kind);
			check_val("write count", wr_addr.size(), exp_addr.size());
			for (int i = 0; i < exp_addr.size(); i++) begin
				check_val("mem_o.addr", wr_addr[i], exp_addr[i]);
				check_val("mem_o.data", wr_data[i], exp_data[i]);
			end
			if (recs[r].kind == KIND_CRT) begin
				check_val("cart_o.id", cart_o.id, recs[r].param);
				check_val("cart_o.exrom", cart_o.exrom, 8'h01);
				check_val("cart_o.game", cart_o.game, 8'h00);
				check_val("cart_attached_o", cart_attached_o, 1);
				check_val("chip count", seen_chip.size(), exp_chip.size());
				foreach (exp_chip[k]) begin
					check_val("chip_o.bank_type", seen_chip[k].bank_type, exp_chip[k].bank_type);
					check_val("chip_o.bank_num", seen_chip[k].bank_num, exp_chip[k].bank_num);
					check_val("chip_o.bank_laddr", seen_chip[k].bank_laddr, exp_chip[k].bank_laddr);
					check_val("chip_o.bank_size", seen_chip[k].bank_size, exp_chip[k].bank_size);
				end
			end
		end

		// Tape playback of the last record
		check_val("tap_mode_o", tap_mode_o, recs[2].param[0]);
		wait_tap_count(8);
		fifo_full_i = 1'b1;
		repeat (40) @(negedge clk_sys);
		fifo_full_i = 1'b0;
		wait_tap_count(16);
		press_play();
		check_val("playing_o", playing_o, 0);
		n = tap_q.size();
		repeat (60) @(negedge clk_sys);
		check_val("tape bytes while paused", tap_q.size(), n);
		press_play();
		check_val("playing_o", playing_o, 1);
		wait_tap_count(recs[2].pay_len);
		repeat (40) @(negedge clk_sys);
		check_val("playing_o", playing_o, 0);
		check_val("tape byte count", tap_q.size(), recs[2].pay_len);
		for (int i = 0; i < recs[2].pay_len; i++)
			check_val("tap_byte_o.data", tap_q[i], exp_data[i]);
		$display(">>> PASS");
		$finish;
	end

	initial begin
		#3ms;
		fail_msg("simulation ran past its time limit");
	end

endmodule

// ==== bench/loader_sva.sv ====
// Concurrent checks on the DMA slot controller
// Write enable qualifying, held slot access, wait release point

`timescale 1ns/1ps

module loader_sva (
	input logic                 clk_sys,
	input logic                 reset_n,
	input logic                 slot_i,
	input logic                 wait_o,
	input loader_pkg::mem_req_t mem_o
);

	we_needs_ce: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_o.we |-> mem_o.ce)
		else $error("memory write enable without chip enable");

	// Access stays fixed for the rest of the slot
	held_in_slot: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(slot_i && $past(slot_i)) |-> $stable(mem_o))
		else $error("memory request changed inside a slot");

	wait_release: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$fell(wait_o) |-> (slot_i && !$past(slot_i)))
		else $error("wait_o fell outside the first cycle of a slot");

endmodule

bind dma_slot_ctrl loader_sva loader_sva_i (
	.clk_sys (clk_sys),
	.reset_n (reset_n),
	.slot_i  (slot_i),
	.wait_o  (wait_o),
	.mem_o   (mem_o)
);

// ==== design/loader_top.sv ====
// Loader top level
// Download decoder, DMA slot controller and tape fetcher

`timescale 1ns/1ps

module loader_top (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  loader_pkg::dl_byte_t   dl_i,
	input  loader_pkg::file_kind_e index_i,
	input  logic                   download_i,
	input  logic                   slot_i,
	input  logic [7:0]             mem_rdata_i,
	input  logic                   play_btn_i,
	input  logic                   fifo_full_i,
	output logic                   wait_o,
	output loader_pkg::mem_req_t   mem_o,
	output loader_pkg::cart_info_t cart_o,
	output loader_pkg::chip_hdr_t  chip_o,
	output logic                   cart_attached_o,
	output logic                   tap_mode_o,
	output loader_pkg::tap_byte_t  tap_byte_o,
	output logic                   playing_o
);
	import loader_pkg::*;

	load_cmd_t         load_cmd;
	logic              tap_done;
	logic              tap_req;
	logic              tap_grant;
	logic [ADDR_W-1:0] tap_addr;
	logic [ADDR_W-1:0] load_addr;

	download_decoder download_decoder_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_i            (dl_i),
		.index_i         (index_i),
		.download_i      (download_i),
		.cmd_o           (load_cmd),
		.cart_o          (cart_o),
		.chip_o          (chip_o),
		.cart_attached_o (cart_attached_o),
		.tap_mode_o      (tap_mode_o),
		.tap_done_o      (tap_done)
	);

	dma_slot_ctrl dma_slot_ctrl_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.cmd_i       (load_cmd),
		.slot_i      (slot_i),
		.download_i  (download_i),
		.tap_req_i   (tap_req),
		.tap_addr_i  (tap_addr),
		.tap_grant_o (tap_grant),
		.load_addr_o (load_addr),
		.wait_o      (wait_o),
		.mem_o       (mem_o)
	);

	tape_fetch tape_fetch_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.tap_done_i  (tap_done),
		.download_i  (download_i),
		.index_i     (index_i),
		.last_addr_i (load_addr),
		.play_btn_i  (play_btn_i),
		.fifo_full_i (fifo_full_i),
		.slot_i      (slot_i),
		.grant_i     (tap_grant),
		.mem_rdata_i (mem_rdata_i),
		.req_o       (tap_req),
		.addr_o      (tap_addr),
		.tap_byte_o  (tap_byte_o),
		.playing_o   (playing_o)
	);

endmodule

// ==== design/tape_fetch.sv ====
// Tape play state and play address
// Requests one tape byte per granted slot while the FIFO has room
// Hands each byte to the tape player as a one-cycle valid

`timescale 1ns/1ps

module tape_fetch (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	input  logic                          tap_done_i,
	input  logic                          download_i,
	input  loader_pkg::file_kind_e        index_i,
	input  logic [loader_pkg::ADDR_W-1:0] last_addr_i,
	input  logic                          play_btn_i,
	input  logic                          fifo_full_i,
	input  logic                          slot_i,
	input  logic                          grant_i,
	input  logic [7:0]                    mem_rdata_i,
	output logic                          req_o,
	output logic [loader_pkg::ADDR_W-1:0] addr_o,
	output loader_pkg::tap_byte_t         tap_byte_o,
	output logic                          playing_o
);
	import loader_pkg::*;

	logic [ADDR_W-1:0] last_addr;
	logic              slot_q;
	logic              btn_q;
	logic              granted;
	logic              slot_fall;
	logic              btn_rise;
	logic              has_data;
	logic              tap_loading;

	assign slot_fall   = slot_q && !slot_i;
	assign btn_rise    = play_btn_i && !btn_q;
	assign has_data    = addr_o < last_addr;
	assign tap_loading = download_i && index_i == KIND_TAP;

	// Read data is sampled in the first cycle after the slot
	always_ff @(posedge clk_sys) begin
		slot_q <= slot_i;
		btn_q  <= play_btn_i;
		if (slot_fall)
			tap_byte_o.data <= mem_rdata_i;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			addr_o           <= TAP_BASE;
			last_addr        <= TAP_BASE;
			playing_o        <= 1'b0;
			req_o            <= 1'b0;
			granted          <= 1'b0;
			tap_byte_o.valid <= 1'b0;
		end else begin
			tap_byte_o.valid <= 1'b0;

			if (playing_o && !has_data)
				playing_o <= 1'b0;
			if (btn_rise && has_data)
				playing_o <= !playing_o;

			if (slot_fall && playing_o && has_data && !fifo_full_i && !granted)
				req_o <= 1'b1;
			if (grant_i) begin
				req_o   <= 1'b0;
				granted <= 1'b1;
			end else if (!playing_o) begin
				req_o <= 1'b0;
			end

			// A byte that meets a full FIFO is fetched again later
			if (slot_fall && granted) begin
				granted <= 1'b0;
				if (!fifo_full_i) begin
					tap_byte_o.valid <= 1'b1;
					addr_o           <= addr_o + 1'b1;
				end
			end

			if (tap_done_i) begin
				last_addr <= last_addr_i;
				playing_o <= 1'b1;
			end
			if (tap_loading) begin
				addr_o    <= TAP_BASE;
				playing_o <= 1'b0;
				req_o     <= 1'b0;
				granted   <= 1'b0;
			end
		end
	end

endmodule

// ==== design/dma_slot_ctrl.sv ====
// Load address counter and pending write byte
// Commits one memory access per DMA slot, load writes before tape reads
// Access is fixed at the slot rising edge and held for the whole slot

`timescale 1ns/1ps

module dma_slot_ctrl (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	input  loader_pkg::load_cmd_t         cmd_i,
	input  logic                          slot_i,
	input  logic                          download_i,
	input  logic                          tap_req_i,
	input  logic [loader_pkg::ADDR_W-1:0] tap_addr_i,
	output logic                          tap_grant_o,
	output logic [loader_pkg::ADDR_W-1:0] load_addr_o,
	output logic                          wait_o,
	output loader_pkg::mem_req_t          mem_o
);
	import loader_pkg::*;

	logic [ADDR_W-1:0] load_addr;
	logic [ADDR_W-1:0] next_addr;
	logic [7:0]        wr_data;
	logic              pending;
	logic              slot_q;
	logic              slot_rise;
	logic              wr_commit;
	logic              rd_commit;
	mem_req_t          commit_req;
	mem_req_t          held_req;

	assign slot_rise = slot_i && !slot_q;
	assign wr_commit = slot_rise && pending;
	assign rd_commit = slot_rise && !pending && !download_i && tap_req_i;

	always_comb begin
		commit_req.ce   = wr_commit || rd_commit;
		commit_req.we   = wr_commit;
		commit_req.addr = wr_commit ? load_addr : tap_addr_i;
		commit_req.data = wr_data;
	end

	// ==============================
	// Slot multiplexer
	// ==============================
	assign mem_o       = !slot_i ? '0 : (slot_rise ? commit_req : held_req);
	assign tap_grant_o = rd_commit;
	assign wait_o      = pending && !wr_commit;
	// End address including a byte still waiting for its slot
	assign load_addr_o = load_addr + ADDR_W'(pending);

	assign next_addr = load_addr + ADDR_W'(wr_commit);

	always_ff @(posedge clk_sys) begin
		slot_q <= slot_i;
		if (slot_rise) begin
			held_req.addr <= commit_req.addr;
			held_req.data <= commit_req.data;
		end
		if (cmd_i.op == OP_PUSH)
			wr_data <= cmd_i.data;
	end

	// ==============================
	// Address counter and pending flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr   <= '0;
			pending     <= 1'b0;
			held_req.ce <= 1'b0;
			held_req.we <= 1'b0;
		end else begin
			if (slot_rise) begin
				held_req.ce <= commit_req.ce;
				held_req.we <= commit_req.we;
			end
			if (wr_commit)
				pending <= 1'b0;
			load_addr <= next_addr;

			case (cmd_i.op)
				OP_SET_LO:    load_addr <= ADDR_W'(cmd_i.data);
				OP_SET_HI:    load_addr <= {next_addr[ADDR_W-1:16], cmd_i.data, next_addr[7:0]};
				OP_BASE_CART: load_addr <= CART_BASE;
				OP_BASE_TAP:  load_addr <= TAP_BASE;
				OP_ALIGN: begin
					// Round up to the next 8 KB boundary
					if (next_addr[ALIGN_BITS-1:0] != '0)
						load_addr <= {next_addr[ADDR_W-1:ALIGN_BITS] + 1'b1, ALIGN_BITS'(0)};
				end
				OP_PUSH:      pending <= 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// ==== design/download_decoder.sv ====
// Per-byte decoder of host downloads
// PRG address bytes and payload, TAP base and payload
// CRT bytes go to the cartridge parser

`timescale 1ns/1ps

module download_decoder (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  loader_pkg::dl_byte_t   dl_i,
	input  loader_pkg::file_kind_e index_i,
	input  logic                   download_i,
	output loader_pkg::load_cmd_t  cmd_o,
	output loader_pkg::cart_info_t cart_o,
	output loader_pkg::chip_hdr_t  chip_o,
	output logic                   cart_attached_o,
	output logic                   tap_mode_o,
	output logic                   tap_done_o
);
	import loader_pkg::*;

	load_cmd_t  crt_cmd;
	load_cmd_t  own_cmd;
	logic       is_prg;
	logic       is_crt;
	logic       is_tap;
	logic       dl_q;
	// TAP offset 0 needs two commands, the push follows the base
	logic       push_defer;
	logic [7:0] defer_data;

	assign is_prg = index_i == KIND_PRG;
	assign is_crt = index_i == KIND_CRT;
	assign is_tap = index_i == KIND_TAP;

	crt_parser crt_parser_i (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.dl_i     (dl_i),
		.active_i (download_i && is_crt),
		.cmd_o    (crt_cmd),
		.cart_o   (cart_o),
		.chip_o   (chip_o)
	);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			own_cmd.op      <= OP_NONE;
			push_defer      <= 1'b0;
			dl_q            <= 1'b0;
			cart_attached_o <= 1'b0;
			tap_mode_o      <= 1'b0;
			tap_done_o      <= 1'b0;
		end else begin
			dl_q         <= download_i;
			own_cmd.op   <= OP_NONE;
			own_cmd.data <= dl_i.data;
			push_defer   <= 1'b0;

			if (push_defer) begin
				own_cmd.op   <= OP_PUSH;
				own_cmd.data <= defer_data;
			end else if (dl_i.wr && download_i) begin
				if (is_prg) begin
					if (dl_i.addr == ADDR_W'(0))
						own_cmd.op <= OP_SET_LO;
					else if (dl_i.addr == ADDR_W'(1))
						own_cmd.op <= OP_SET_HI;
					else
						own_cmd.op <= OP_PUSH;
				end
				if (is_tap) begin
					own_cmd.op <= OP_PUSH;
					if (dl_i.addr == '0) begin
						own_cmd.op <= OP_BASE_TAP;
						push_defer <= 1'b1;
						defer_data <= dl_i.data;
					end
					if (dl_i.addr == ADDR_W'(TAP_MODE_OFS))
						tap_mode_o <= dl_i.data[0];
				end
			end

			// Cartridge is attached once its download has finished
			if (is_crt && dl_q != download_i)
				cart_attached_o <= dl_q;
			tap_done_o <= is_tap && dl_q && !download_i;
		end
	end

	assign cmd_o = (crt_cmd.op != OP_NONE) ? crt_cmd : own_cmd;

endmodule

// ==== design/crt_parser.sv ====
// Cartridge image parser
// Captures id, EXROM and GAME from the cartridge header
// Walks the chip packets and emits align and push commands

`timescale 1ns/1ps

module crt_parser (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  loader_pkg::dl_byte_t   dl_i,
	input  logic                   active_i,
	output loader_pkg::load_cmd_t  cmd_o,
	output loader_pkg::cart_info_t cart_o,
	output loader_pkg::chip_hdr_t  chip_o
);
	import loader_pkg::*;

	// Byte index inside the chip packet header, zero while in payload
	logic [3:0]  hdr_cnt;
	// Payload bytes left in the current chip packet
	logic [31:0] blk_len;
	logic        in_chips;
	logic        hdr_last;

	assign in_chips = dl_i.addr >= ADDR_W'(CRT_CHIP_START);
	assign hdr_last = hdr_cnt == 4'(CHIP_HDR_LEN - 1);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt      <= '0;
			blk_len      <= '0;
			cmd_o.op     <= OP_NONE;
			chip_o.valid <= 1'b0;
		end else begin
			cmd_o.op     <= OP_NONE;
			cmd_o.data   <= dl_i.data;
			chip_o.valid <= 1'b0;

			if (dl_i.wr && active_i) begin
				if (dl_i.addr == '0) begin
					cmd_o.op <= OP_BASE_CART;
					hdr_cnt  <= '0;
					blk_len  <= '0;
				end

				// Cartridge header fields
				case (dl_i.addr)
					ADDR_W'('h16): cart_o.id[15:8] <= dl_i.data;
					ADDR_W'('h17): cart_o.id[7:0]  <= dl_i.data;
					ADDR_W'('h18): cart_o.exrom    <= dl_i.data;
					ADDR_W'('h19): cart_o.game     <= dl_i.data;
					default: ;
				endcase

				if (in_chips) begin
					if (hdr_cnt == '0 && blk_len == '0) begin
						// First byte of a new chip packet
						cmd_o.op <= OP_ALIGN;
						hdr_cnt  <= 4'd1;
					end else if (hdr_cnt != '0) begin
						hdr_cnt      <= hdr_last ? '0 : hdr_cnt + 1'b1;
						chip_o.valid <= hdr_last;
						case (hdr_cnt)
							4'd4:  blk_len[31:24]           <= dl_i.data;
							4'd5:  blk_len[23:16]           <= dl_i.data;
							4'd6:  blk_len[15:8]            <= dl_i.data;
							4'd7:  blk_len[7:0]             <= dl_i.data;
							// Packet length includes its own header
							4'd8:  blk_len <= blk_len - 32'(CHIP_HDR_LEN);
							4'd9:  chip_o.bank_type         <= dl_i.data;
							4'd10: chip_o.bank_num[15:8]    <= dl_i.data;
							4'd11: chip_o.bank_num[7:0]     <= dl_i.data;
							4'd12: chip_o.bank_laddr[15:8]  <= dl_i.data;
							4'd13: chip_o.bank_laddr[7:0]   <= dl_i.data;
							4'd14: chip_o.bank_size[15:8]   <= dl_i.data;
							4'd15: chip_o.bank_size[7:0]    <= dl_i.data;
							default: ;
						endcase
					end else begin
						cmd_o.op <= OP_PUSH;
						blk_len  <= blk_len - 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== design/loader_pkg.sv ====
// Shared definitions for the download and memory-slot loader
// Memory map bases and CRT/TAP file layout offsets
// File kind and load command enums
// Packed structs for host bytes, commands, memory requests and headers

package loader_pkg;

	// ==============================
	// Memory map and file layout
	// ==============================
	localparam int ADDR_W = 25;

	localparam logic [ADDR_W-1:0] CART_BASE = 25'h100000;
	localparam logic [ADDR_W-1:0] TAP_BASE  = 25'h200000;

	// CRT chip packets start after the 64 byte cartridge header
	localparam int CRT_CHIP_START = 'h40;
	localparam int CHIP_HDR_LEN   = 16;
	localparam int ALIGN_BITS     = 13;

	// Tape version byte of a TAP file
	localparam int TAP_MODE_OFS = 12;

	// ==============================
	// Enums
	// ==============================
	typedef enum logic [7:0] {
		KIND_PRG = 8'd2,
		KIND_CRT = 8'd3,
		KIND_TAP = 8'd4
	} file_kind_e;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_SET_LO,
		OP_SET_HI,
		OP_BASE_CART,
		OP_BASE_TAP,
		OP_ALIGN,
		OP_PUSH
	} load_op_e;

	// ==============================
	// Structs
	// ==============================
	typedef struct packed {
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} dl_byte_t;

	typedef struct packed {
		load_op_e   op;
		logic [7:0] data;
	} load_cmd_t;

	typedef struct packed {
		logic              ce;
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_req_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

	typedef struct packed {
		logic        valid;
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] bank_laddr;
		logic [15:0] bank_size;
	} chip_hdr_t;

	// Byte handed to the tape player
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} tap_byte_t;

endpackage
